// ==== design/led_matrix_pkg.sv ====
package led_matrix_pkg;

    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 8;

    typedef logic [$clog2(MATRIX_ROWS)-1:0] row_idx_t;
    typedef logic [MATRIX_COLS-1:0]         row_bits_t;   // bit c drives column c

    // one frame seen as row bytes or as two bus words
    typedef union packed
    {
        row_bits_t [MATRIX_ROWS-1:0] rows;    // row r at bits 8r+7..8r
        logic [1:0][31:0]            words;   // word 0 holds rows 0..3
    } frame_u;

    typedef enum logic [2:0]
    {
        ORIENT_PLAIN     = 3'd0,
        ORIENT_MIRROR    = 3'd1,   // columns reversed
        ORIENT_PLAIN_ALT = 3'd2,   // same picture as plain
        ORIENT_ROT_UP    = 3'd3,
        ORIENT_ROT_DOWN  = 3'd4
    } orient_e;

    localparam logic [1:0] ADDR_FRAME_LO = 2'd0;
    localparam logic [1:0] ADDR_FRAME_HI = 2'd1;
    localparam logic [1:0] ADDR_MODE     = 2'd2;

    typedef struct packed
    {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] wdata;
    } wb_req_t;

    typedef struct packed
    {
        logic        ack;
        logic [31:0] rdata;
    } wb_rsp_t;

endpackage

// ==== design/led_matrix_top.sv ====
module led_matrix_top #(
    parameter int CLK_FREQ  = 10000000,
    parameter int SCAN_FREQ = 125000
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  led_matrix_pkg::wb_req_t                bus_req,
    output led_matrix_pkg::wb_rsp_t                bus_rsp,
    output logic [led_matrix_pkg::MATRIX_ROWS-1:0] row_sel,
    output led_matrix_pkg::row_bits_t              col_sel
);
    import led_matrix_pkg::*;

    logic      frame_start;
    logic      load;
    row_idx_t  row_idx;
    frame_u    active_frame;
    orient_e   active_mode;
    row_bits_t row_pattern;

    scan_ctrl #(
        .CLK_FREQ  (CLK_FREQ),
        .SCAN_FREQ (SCAN_FREQ)
    ) u_scan_ctrl (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .load        (load),
        .row_idx     (row_idx)
    );

    wb_frame_regs u_wb_frame_regs (
        .clk          (clk),
        .rst          (rst),
        .frame_start  (frame_start),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .active_frame (active_frame),
        .active_mode  (active_mode)
    );

    row_orient u_row_orient (
        .active_frame (active_frame),
        .active_mode  (active_mode),
        .row_idx      (row_idx),
        .row_pattern  (row_pattern)
    );

    row_driver u_row_driver (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .row_idx     (row_idx),
        .row_pattern (row_pattern),
        .row_sel     (row_sel),
        .col_sel     (col_sel)
    );

endmodule

// ==== design/row_driver.sv ====
module row_driver (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   load,
    input  led_matrix_pkg::row_idx_t               row_idx,
    input  led_matrix_pkg::row_bits_t              row_pattern,
    output logic [led_matrix_pkg::MATRIX_ROWS-1:0] row_sel,
    output led_matrix_pkg::row_bits_t              col_sel
);
    import led_matrix_pkg::*;

    logic [MATRIX_ROWS-1:0] row_onehot;
    logic                   row_empty;

    assign row_empty  = (row_pattern == '0);
    assign row_onehot = MATRIX_ROWS'(1) << row_idx;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_sel <= '1;   // all rows off
            col_sel <= '0;
        end
        else if (load)
        begin
            col_sel <= row_pattern;
            if (row_empty)
                row_sel <= '1;   // empty row stays dark
            else
                row_sel <= ~row_onehot;   // active low
        end
    end

    a_one_row: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(~row_sel)
    ) else $error("row_driver: more than one row selected");

endmodule

// ==== design/row_orient.sv ====
module row_orient (
    input  led_matrix_pkg::frame_u    active_frame,
    input  led_matrix_pkg::orient_e   active_mode,
    input  led_matrix_pkg::row_idx_t  row_idx,
    output led_matrix_pkg::row_bits_t row_pattern
);
    import led_matrix_pkg::*;

    localparam row_idx_t ROW_LAST = row_idx_t'(MATRIX_ROWS - 1);

    row_bits_t plain_row;
    row_bits_t mirror_row;
    row_bits_t up_row;
    row_bits_t down_row;
    row_idx_t  flip_idx;

    assign flip_idx  = ROW_LAST - row_idx;   // 7 - r
    assign plain_row = active_frame.rows[row_idx];

    // rotations take a column slice, so the matrix has to be square
    always_comb
    begin
        for (int c = 0; c < MATRIX_COLS; c++)
        begin
            mirror_row[c] = plain_row[MATRIX_COLS-1-c];
            up_row[c]     = active_frame.rows[c][flip_idx];
            down_row[c]   = active_frame.rows[MATRIX_ROWS-1-c][row_idx];
        end
    end

    always_comb
    begin
        case (active_mode)
            ORIENT_PLAIN,
            ORIENT_PLAIN_ALT: row_pattern = plain_row;
            ORIENT_MIRROR:    row_pattern = mirror_row;
            ORIENT_ROT_UP:    row_pattern = up_row;     // in[c][7-r]
            ORIENT_ROT_DOWN:  row_pattern = down_row;   // in[7-c][r]
            default:          row_pattern = '0;         // modes 5..7 show nothing
        endcase
    end

endmodule

// ==== design/scan_ctrl.sv ====
module scan_ctrl #(
    parameter int CLK_FREQ  = 10000000,
    parameter int SCAN_FREQ = 125000
) (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     frame_start,
    output logic                     load,
    output led_matrix_pkg::row_idx_t row_idx
);
    import led_matrix_pkg::*;

    localparam int SCAN_DIV = CLK_FREQ / (SCAN_FREQ * MATRIX_ROWS);
    localparam int TIMER_W  = (SCAN_DIV > 2) ? $clog2(SCAN_DIV) : 1;

    localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(SCAN_DIV - 1);
    localparam row_idx_t           ROW_LAST   = row_idx_t'(MATRIX_ROWS - 1);

    logic [TIMER_W-1:0] timer;
    logic               terminal;

    if (SCAN_DIV < 2)
    begin : g_div_check
        $fatal(1, "scan_ctrl: clock too slow for scan rate, SCAN_DIV = %0d", SCAN_DIV);
    end

    assign terminal = (timer == TIMER_LAST);

    // active regs load on the same edge that brings row 0
    assign frame_start = terminal && (row_idx == ROW_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            timer   <= '0;
            row_idx <= ROW_LAST;   // first advance lands on row 0
            load    <= 1'b0;
        end
        else
        begin
            load <= terminal;   // one cycle after row_idx moves
            if (terminal)
            begin
                timer <= '0;
                if (row_idx == ROW_LAST)
                    row_idx <= '0;
                else
                    row_idx <= row_idx + 1'b1;
            end
            else
            begin
                timer <= timer + 1'b1;
            end
        end
    end

    a_load_apart: assert property (
        @(posedge clk) disable iff (rst)
        !(load && frame_start)
    ) else $error("scan_ctrl: load and frame_start in the same cycle");

endmodule

// ==== design/wb_frame_regs.sv ====
module wb_frame_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_start,
    input  led_matrix_pkg::wb_req_t bus_req,
    output led_matrix_pkg::wb_rsp_t bus_rsp,
    output led_matrix_pkg::frame_u  active_frame,
    output led_matrix_pkg::orient_e active_mode
);
    import led_matrix_pkg::*;

    frame_u      shadow_frame;
    orient_e     shadow_mode;
    logic        ack_q;
    logic        access;
    logic [31:0] rd_data;

    assign access = bus_req.cyc && bus_req.stb && !ack_q;   // request not yet answered

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ack_q <= 1'b0;
        else
            ack_q <= access;   // single cycle, drops next
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shadow_frame <= '0;
            shadow_mode  <= ORIENT_PLAIN;
        end
        else if (access && bus_req.we)
        begin
            case (bus_req.adr)
                ADDR_FRAME_LO: shadow_frame.words[0] <= bus_req.wdata;
                ADDR_FRAME_HI: shadow_frame.words[1] <= bus_req.wdata;
                ADDR_MODE:     shadow_mode <= orient_e'(bus_req.wdata[2:0]);
                default:       ;   // addr 3 has no register
            endcase
        end
    end

    // shadow copies go live only between frames so a scan never tears
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            active_frame <= '0;
            active_mode  <= ORIENT_PLAIN;
        end
        else if (frame_start)
        begin
            active_frame <= shadow_frame;
            active_mode  <= shadow_mode;
        end
    end

    always_comb
    begin
        case (bus_req.adr)
            ADDR_FRAME_LO: rd_data = shadow_frame.words[0];
            ADDR_FRAME_HI: rd_data = shadow_frame.words[1];
            ADDR_MODE:     rd_data = {29'd0, shadow_mode};
            default:       rd_data = '0;
        endcase
    end

    assign bus_rsp = '{ack: ack_q, rdata: rd_data};

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst)
        ack_q |=> !ack_q
    ) else $error("wb_frame_regs: ack held longer than one cycle");

    a_ack_req: assert property (
        @(posedge clk) disable iff (rst)
        ack_q |-> $past(bus_req.cyc && bus_req.stb)
    ) else $error("wb_frame_regs: ack without a preceding request");

endmodule

// ==== project.f ====
+incdir+sim
design/led_matrix_pkg.sv
design/scan_ctrl.sv
design/wb_frame_regs.sv
design/row_orient.sv
design/row_driver.sv
design/led_matrix_top.sv
sim/tb_led_matrix.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and check the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_led_matrix -f project.f -o tb_led_matrix \
    && ./obj_dir/tb_led_matrix | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// ==== sim/tb_matrix_model.svh ====
`ifndef TB_MATRIX_MODEL_SVH
`define TB_MATRIX_MODEL_SVH

// cycle model of the scan, bus registers and output stage
int          exp_timer;
int          exp_row;
logic        exp_load;
logic        exp_ack;
logic [7:0]  exp_row_sel;
logic [7:0]  exp_col_sel;
logic [63:0] shadow_frame;
logic [2:0]  shadow_mode;
logic [63:0] live_frame;
logic [2:0]  live_mode;
int          frames_committed;

// pixel at row r, column c of a 64-bit frame
function automatic logic pixel(input logic [63:0] f, input int r, input int c);
    return f[8*r + c];
endfunction

function automatic logic [7:0] orient_row(input logic [63:0] f, input logic [2:0] mode,
                                          input int r);
    logic [7:0] pattern;
    pattern = 8'h00;
    for (int c = 0; c < 8; c++)
    begin
        case (mode)
            3'd0, 3'd2: pattern[c] = pixel(f, r, c);
            3'd1:       pattern[c] = pixel(f, r, 7 - c);
            3'd3:       pattern[c] = pixel(f, c, 7 - r);
            3'd4:       pattern[c] = pixel(f, 7 - c, r);
            default:    pattern[c] = 1'b0;   // unknown mode stays dark
        endcase
    end
    return pattern;
endfunction

function automatic logic [7:0] select_mask(input logic [7:0] pattern, input int r);
    if (pattern == 8'h00)
        return 8'hff;
    return ~(8'h01 << r);   // active low
endfunction

task automatic reset_model();
    exp_timer        = 0;
    exp_row          = 7;
    exp_load         = 1'b0;
    exp_ack          = 1'b0;
    exp_row_sel      = 8'hff;
    exp_col_sel      = 8'h00;
    shadow_frame     = 64'd0;
    shadow_mode      = 3'd0;
    live_frame       = 64'd0;
    live_mode        = 3'd0;
    frames_committed = 0;
endtask

// one rising edge, everything read from the state before the edge
task automatic step_model(input wb_req_t req);
    logic terminal;
    logic access;
    terminal = (exp_timer == SCAN_DIV - 1);
    access   = req.cyc && req.stb && !exp_ack;
    if (exp_load)
    begin
        exp_col_sel = orient_row(live_frame, live_mode, exp_row);
        exp_row_sel = select_mask(exp_col_sel, exp_row);
    end
    if (terminal && exp_row == 7)
    begin
        live_frame = shadow_frame;   // commit before this edge's write lands
        live_mode  = shadow_mode;
        frames_committed++;
    end
    if (access && req.we)
    begin
        case (req.adr)
            ADDR_FRAME_LO: shadow_frame[31:0]  = req.wdata;
            ADDR_FRAME_HI: shadow_frame[63:32] = req.wdata;
            ADDR_MODE:     shadow_mode         = req.wdata[2:0];
            default:       ;
        endcase
    end
    exp_load = terminal;
    exp_ack  = access;
    if (terminal)
    begin
        exp_timer = 0;
        exp_row   = (exp_row + 1) % 8;
    end
    else
        exp_timer++;
endtask

`endif

// ==== sim/tb_led_matrix.sv ====
module tb_led_matrix;
    timeunit 1ns;
    timeprecision 1ps;

    import led_matrix_pkg::*;

    localparam int CLK_FREQ   = 800;
    localparam int SCAN_FREQ  = 25;
    localparam int SCAN_DIV   = CLK_FREQ / (SCAN_FREQ * 8);
    localparam int RESET_CYC  = 16;
    localparam int N_BUS      = 16;
    localparam int N_PLAIN    = 4;
    localparam int N_PER_MODE = 2;
    localparam int N_MID      = 3;
    localparam int FRAMES     = 2 * N_PLAIN + 2 * 7 * N_PER_MODE + 4 * N_MID;
    localparam int BUS_CYC    = RESET_CYC + 4 * (N_BUS + 1)
                              + 6 * (N_PLAIN + 7 * N_PER_MODE + 2 * N_MID);
    localparam int CYCLE_LIMIT = 2 * (FRAMES * 8 * SCAN_DIV + BUS_CYC);

    logic       clk;
    logic       rst;
    wb_req_t    bus_req;
    wb_rsp_t    bus_rsp;
    logic [7:0] row_sel;
    row_bits_t  col_sel;

    int checks;
    int value_errors;
    int timeout_errors;
    int cycles;

    `include "tb_matrix_model.svh"

    led_matrix_top #(
        .CLK_FREQ  (CLK_FREQ),
        .SCAN_FREQ (SCAN_FREQ)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .row_sel (row_sel),
        .col_sel (col_sel)
    );

    always #10 clk = ~clk;

    always @(posedge clk or posedge rst)
    begin
        if (rst)
            reset_model();
        else
            step_model(bus_req);
    end

    // outputs are settled at the falling edge
    always @(negedge clk)
    begin
        checks++;
        assert (row_sel === exp_row_sel && col_sel === exp_col_sel)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t: row %0d mode %0d, row_sel %b col_sel %b, expected %b %b",
                     $time, exp_row, live_mode, row_sel, col_sel, exp_row_sel, exp_col_sel);
        end
        assert (bus_rsp.ack === exp_ack)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t: ack %b, expected %b", $time, bus_rsp.ack, exp_ack);
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            timeout_errors++;
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            finish_run();
        end
    end

    task automatic finish_run();
        $display("checks %0d, value errors %0d, timeouts %0d",
                 checks, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        assert (got === want)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t: %s read %h, expected %h", $time, what, got, want);
        end
    endtask

    // starts and ends on a falling edge
    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waits;
        waits   = 0;
        bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, wdata: wdata};
        do
        begin
            @(negedge clk);
            waits++;
        end while (!bus_rsp.ack);
        rdata = bus_rsp.rdata;
        checks++;
        assert (waits == 1)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t: ack came %0d cycles after the request", $time, waits);
        end
        bus_req = '0;
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [1:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic load_frame(input logic [63:0] f, input logic [2:0] mode);
        bus_write(ADDR_FRAME_LO, f[31:0]);
        bus_write(ADDR_FRAME_HI, f[63:32]);
        bus_write(ADDR_MODE, {29'd0, mode});
    endtask

    task automatic wait_commits(input int n);
        int target;
        target = frames_committed + n;
        while (frames_committed < target)
            @(negedge clk);
    endtask

    function automatic logic [63:0] random_frame();
        logic [63:0] f;
        f = {$urandom(), $urandom()};
        for (int r = 0; r < 8; r++)
        begin
            if ($urandom_range(0, 3) == 0)
                f[8*r +: 8] = 8'h00;   // some rows left empty
        end
        return f;
    endfunction

    initial
    begin
        logic [63:0] f_new;
        logic [2:0]  mode_new;
        logic [1:0]  adr;
        logic [31:0] wval;
        logic [31:0] rval;
        logic [7:0]  row0;
        clk     = 1'b0;
        rst     = 1'b1;
        bus_req = '0;
        checks  = 0;
        value_errors   = 0;
        timeout_errors = 0;
        cycles  = 0;
        reset_model();
        void'($urandom(32'h67e25e07));
        repeat (RESET_CYC) @(negedge clk);
        rst = 1'b0;
        checks++;
        assert (row_sel === 8'hff && col_sel === 8'h00 && bus_rsp.ack === 1'b0)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t: outputs not at reset values after reset", $time);
        end

        for (int i = 0; i < N_BUS; i++)
        begin
            adr  = 2'($urandom_range(0, 2));
            wval = $urandom();
            bus_write(adr, wval);
            bus_read(adr, rval);
            compare_word("register", rval, (adr == ADDR_MODE) ? (wval & 32'h7) : wval);
        end
        bus_write(2'd3, $urandom());
        bus_read(2'd3, rval);
        compare_word("address 3", rval, 32'd0);

        for (int i = 0; i < N_PLAIN; i++)
        begin
            load_frame(random_frame(), ($urandom_range(0, 1) == 0) ? 3'd0 : 3'd2);
            wait_commits(2);
        end

        for (int m = 1; m < 8; m++)
        begin
            for (int i = 0; i < N_PER_MODE; i++)
            begin
                load_frame(random_frame(), 3'(m));
                wait_commits(2);
            end
        end

        // rewrite halfway through a scan
        for (int i = 0; i < N_MID; i++)
        begin
            load_frame(random_frame(), 3'($urandom_range(0, 4)));
            wait_commits(1);
            while (exp_row != 3)
                @(negedge clk);
            f_new    = random_frame();
            mode_new = 3'($urandom_range(0, 4));
            load_frame(f_new, mode_new);
            wait_commits(1);
            @(negedge clk);   // row 0 of the new frame loaded
            row0 = orient_row(f_new, mode_new, 0);
            checks++;
            assert (col_sel === row0 && row_sel === select_mask(row0, 0))
            else
            begin
                value_errors++;
                $display("[FAIL] %0t: first row after rewrite %b %b, expected %b %b",
                         $time, row_sel, col_sel, select_mask(row0, 0), row0);
            end
            wait_commits(1);
        end

        finish_run();
    end

endmodule
